/* src/conv_sequencer.sv */
// stride 1 only; out_w*out_w must fit one 256-entry psum bank, K is 4 or 5
module conv_sequencer import nn_ctrl_pkg::*; (
	input  logic        i_clk,
	input  logic        i_rst,
	input  cfg_t        i_cfg,
	input  logic        i_start,
	input  logic [1:0]  i_bank_full,
	output slide_ctrl_t o_slide,
	output pmem_port_t  o_pmem0,
	output pmem_port_t  o_pmem1,
	output logic        o_bank_release,
	output logic        o_layer_done
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT, // for a full weight bank
		S_RUN
	} seq_e;

	seq_e               state;
	logic [KSTEP_W-1:0] k_val;
	logic [KSTEP_W-1:0] fill_cnt; // rows held in the window
	logic [KSTEP_W-1:0] step_cnt;
	logic [DIM_W-1:0]   row_cnt;
	logic [DIM_W-1:0]   col_cnt;
	logic [CH_W-1:0]    ch_cnt;
	logic [WMEM_AW-1:0] wrow;
	logic [PMEM_AW-1:0] pix_addr;
	logic               cur_bank;
	logic               is_step;
	logic               last_step;
	logic               last_row;
	logic               last_col;
	logic               last_ch;
	logic               shift_q;
	logic               step_q;
	logic [KSTEP_W-1:0] wgt_q;
	logic               acc_q;
	logic               rd_par_q;
	logic [PMEM_AW-1:0] rd_addr_q;
	logic               wr_q;
	logic               wr_bank_q;
	logic [PMEM_AW-1:0] wr_addr_q;

	assign k_val     = (i_cfg.mode == MODE_K5) ? KSTEP_W'(5) : KSTEP_W'(4);
	assign is_step   = (state == S_RUN) && (fill_cnt == k_val);
	assign last_step = (step_cnt == k_val - 1'b1);
	assign last_row  = (row_cnt == i_cfg.out_w - 1'b1);
	assign last_col  = (col_cnt == i_cfg.out_w - 1'b1);
	assign last_ch   = (ch_cnt == i_cfg.img_c - 1'b1);

	assign o_slide = '{shift: shift_q, wgt_shift: wgt_q, step_valid: step_q, bias_sel: acc_q};

	// read from bank c mod 2, write to the other one
	assign o_pmem0 = '{wr_en: wr_q & ~wr_bank_q, wr_addr: wr_addr_q,
		rd_en: acc_q & ~rd_par_q, rd_addr: rd_addr_q};
	assign o_pmem1 = '{wr_en: wr_q & wr_bank_q, wr_addr: wr_addr_q,
		rd_en: acc_q & rd_par_q, rd_addr: rd_addr_q};

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state          <= S_IDLE;
			fill_cnt       <= '0;
			step_cnt       <= '0;
			row_cnt        <= '0;
			col_cnt        <= '0;
			ch_cnt         <= '0;
			wrow           <= '0;
			pix_addr       <= '0;
			cur_bank       <= 1'b0;
			shift_q        <= 1'b0;
			step_q         <= 1'b0;
			wgt_q          <= '0;
			acc_q          <= 1'b0;
			rd_par_q       <= 1'b0;
			wr_q           <= 1'b0;
			wr_bank_q      <= 1'b0;
			o_bank_release <= 1'b0;
			o_layer_done   <= 1'b0;
		end else begin
			wr_q           <= step_q; // write trails its read by one cycle
			wr_bank_q      <= ~rd_par_q;
			shift_q        <= 1'b0;
			step_q         <= 1'b0;
			wgt_q          <= '0;
			acc_q          <= 1'b0;
			o_bank_release <= 1'b0;
			o_layer_done   <= 1'b0;
			case (state)
				S_IDLE: begin
					if (i_start) begin
						state    <= S_WAIT;
						fill_cnt <= '0;
						step_cnt <= '0;
						row_cnt  <= '0;
						col_cnt  <= '0;
						ch_cnt   <= '0;
						wrow     <= '0;
						pix_addr <= '0;
						cur_bank <= 1'b0;
					end
				end
				S_WAIT: begin
					if (i_bank_full[cur_bank])
						state <= S_RUN;
				end
				S_RUN: begin
					if (!is_step) begin
						shift_q  <= 1'b1;
						fill_cnt <= fill_cnt + 1'b1;
					end else begin
						step_q   <= 1'b1;
						wgt_q    <= step_cnt;
						acc_q    <= (ch_cnt != '0); // channel 0 starts from bias
						rd_par_q <= ch_cnt[0];
						step_cnt <= step_cnt + 1'b1;
						if (last_step) begin
							step_cnt <= '0;
							row_cnt  <= row_cnt + 1'b1;
							pix_addr <= pix_addr + 1'b1;
							fill_cnt <= k_val - 1'b1; // one new row before next pixel
							if (last_row) begin
								row_cnt  <= '0;
								fill_cnt <= '0;
								col_cnt  <= col_cnt + 1'b1;
								if (last_col) begin
									col_cnt  <= '0;
									pix_addr <= '0;
									ch_cnt   <= ch_cnt + 1'b1;
									wrow     <= wrow + 1'b1;
									if (last_ch || (wrow == '1)) begin
										o_bank_release <= 1'b1;
										cur_bank       <= ~cur_bank;
										wrow           <= '0;
										state          <= S_WAIT;
									end
									if (last_ch) begin
										o_layer_done <= 1'b1;
										state        <= S_IDLE;
									end
								end
							end
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		wr_addr_q <= rd_addr_q;
		if (is_step)
			rd_addr_q <= pix_addr;
	end

endmodule

/* src/dma_beat_packer.sv */
// beats are taken only while no packed word waits; first beat lands in bits 15:0
module dma_beat_packer import nn_ctrl_pkg::*; (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic [DMA_W-1:0]  i_beat_data,
	input  logic              i_beat_valid,
	input  logic              i_word_ready,
	output logic              o_beat_ready,
	output logic [WORD_W-1:0] o_word_data,
	output logic              o_word_valid
);

	logic [1:0] beat_cnt;
	logic       beat_fire;
	logic       last_beat;
	logic       word_valid_nxt;

	assign beat_fire = i_beat_valid & o_beat_ready;
	assign last_beat = beat_fire && (beat_cnt == 2'(BEATS_PER_WORD - 1));

	always_comb begin
		word_valid_nxt = o_word_valid;
		if (o_word_valid && i_word_ready)
			word_valid_nxt = 1'b0;
		if (last_beat)
			word_valid_nxt = 1'b1;
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			beat_cnt     <= '0;
			o_word_valid <= 1'b0;
			o_beat_ready <= 1'b0;
		end else begin
			o_word_valid <= word_valid_nxt;
			o_beat_ready <= ~word_valid_nxt; // stall while a word is held
			if (last_beat)
				beat_cnt <= '0;
			else if (beat_fire)
				beat_cnt <= beat_cnt + 2'd1;
		end
	end

	// shift in from the top
	always_ff @(posedge i_clk) begin
		if (beat_fire)
			o_word_data <= {i_beat_data, o_word_data[WORD_W-1:DMA_W]};
	end

endmodule

/* src/layer_phase_ctrl.sv */
// all image words come before the first weight word; o_done is a single-cycle pulse
module layer_phase_ctrl import nn_ctrl_pkg::*; (
	input  logic              i_clk,
	input  logic              i_rst,
	input  cfg_t              i_cfg,
	input  logic              i_start,
	input  logic [WORD_W-1:0] i_word_data,
	input  logic              i_word_valid,
	input  logic              i_wgt_ready,
	input  logic              i_layer_done,
	output logic              o_word_ready,
	output logic              o_wgt_valid,
	output img_wr_t           o_img_wr,
	output phase_e            o_phase,
	output logic              o_busy,
	output logic              o_done
);

	phase_e             phase;
	logic [IMEM_AW-1:0] img_cnt;
	logic               img_fire;
	logic               img_en_q;
	logic [IMEM_AW-1:0] img_addr_q;
	logic [WORD_W-1:0]  img_data_q;

	always_comb begin
		case (phase)
			PH_LOAD_IMG: o_word_ready = 1'b1;
			PH_COMPUTE:  o_word_ready = i_wgt_ready; // weight writer decides
			default:     o_word_ready = 1'b0;
		endcase
	end

	assign o_wgt_valid = (phase == PH_COMPUTE) & i_word_valid;
	assign img_fire    = (phase == PH_LOAD_IMG) & i_word_valid;
	assign o_phase     = phase;
	assign o_busy      = (phase != PH_IDLE);
	assign o_done      = (phase == PH_DONE);
	assign o_img_wr    = '{en: img_en_q, addr: img_addr_q, data: img_data_q};

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			phase    <= PH_IDLE;
			img_cnt  <= '0;
			img_en_q <= 1'b0;
		end else begin
			img_en_q <= img_fire;
			case (phase)
				PH_IDLE: begin
					img_cnt <= '0;
					if (i_start)
						phase <= PH_LOAD_IMG;
				end
				PH_LOAD_IMG: begin
					if (img_fire) begin
						img_cnt <= img_cnt + 1'b1;
						if (img_cnt == i_cfg.img_words)
							phase <= PH_COMPUTE;
					end
				end
				PH_COMPUTE: begin
					if (i_layer_done)
						phase <= PH_DONE;
				end
				default: phase <= PH_IDLE; // done lasts one cycle
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (img_fire) begin
			img_addr_q <= img_cnt;
			img_data_q <= i_word_data;
		end
	end

endmodule

/* src/nn_cfg_regs.sv */
// writes are dropped while a layer runs; img_c and out_w must be programmed nonzero
module nn_cfg_regs import nn_ctrl_pkg::*; (
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic        i_cfg_wr_en,
	input  cfg_reg_e    i_cfg_addr,
	input  logic [15:0] i_cfg_wdata,
	input  logic        i_busy,
	output cfg_t        o_cfg,
	output logic        o_start
);

	logic wr_ok;
	logic mode_ok;

	// o_start blocks a second start before busy rises
	assign wr_ok   = i_cfg_wr_en & ~i_busy & ~o_start;
	assign mode_ok = (i_cfg_wdata == 16'(MODE_K4)) || (i_cfg_wdata == 16'(MODE_K5));

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_cfg.mode      <= MODE_K4;
			o_cfg.img_c     <= '0;
			o_cfg.out_w     <= '0;
			o_cfg.img_words <= '0;
			o_start         <= 1'b0;
		end else begin
			o_start <= wr_ok && (i_cfg_addr == REG_START);
			if (wr_ok) begin
				case (i_cfg_addr)
					REG_MODE: begin
						if (mode_ok)
							o_cfg.mode <= kmode_e'(i_cfg_wdata[1:0]);
					end
					REG_IMG_C: begin
						o_cfg.img_c <= i_cfg_wdata[CH_W-1:0];
					end
					REG_OUT_W: begin
						o_cfg.out_w <= i_cfg_wdata[DIM_W-1:0];
					end
					REG_IMG_WORDS: begin
						o_cfg.img_words <= i_cfg_wdata[IMEM_AW-1:0];
					end
					default: ; // start handled above
				endcase
			end
		end
	end

endmodule

/* src/nn_ctrl_pkg.sv */
// stride 1 only, kernel modes 4x4 and 5x5; mode codes 0 and 3 are rejected by the register block
package nn_ctrl_pkg;

	localparam int DMA_W          = 16;
	localparam int BEATS_PER_WORD = 3;
	localparam int WORD_W         = DMA_W * BEATS_PER_WORD; // 48
	localparam int COL_NUM        = 6;
	localparam int IMEM_AW        = 10;
	localparam int WMEM_AW        = 7;  // 128 rows per bank
	localparam int PMEM_AW        = 8;
	localparam int CH_W           = 9;
	localparam int DIM_W          = 8;
	localparam int KSTEP_W        = 3;

	typedef enum logic [1:0] {
		PH_IDLE     = 2'd0,
		PH_LOAD_IMG = 2'd1,
		PH_COMPUTE  = 2'd2, // weights stream in while computing
		PH_DONE     = 2'd3
	} phase_e;

	typedef enum logic [1:0] {
		MODE_K4 = 2'd1,
		MODE_K5 = 2'd2
	} kmode_e;

	typedef enum logic [2:0] {
		REG_MODE      = 3'd0,
		REG_IMG_C     = 3'd1,
		REG_OUT_W     = 3'd2,
		REG_IMG_WORDS = 3'd3,
		REG_START     = 3'd4
	} cfg_reg_e;

	typedef struct packed {
		kmode_e             mode;
		logic [CH_W-1:0]    img_c;
		logic [DIM_W-1:0]   out_w;     // width and height
		logic [IMEM_AW-1:0] img_words; // count minus one
	} cfg_t;

	typedef struct packed {
		logic               en;
		logic [IMEM_AW-1:0] addr;
		logic [WORD_W-1:0]  data;
	} img_wr_t;

	typedef struct packed {
		logic [COL_NUM-1:0] en; // one-hot column
		logic [WMEM_AW-1:0] addr;
		logic [WORD_W-1:0]  data;
	} wmem_wr_t;

	typedef struct packed {
		logic               wr_en;
		logic [PMEM_AW-1:0] wr_addr;
		logic               rd_en;
		logic [PMEM_AW-1:0] rd_addr;
	} pmem_port_t;

	typedef struct packed {
		logic               shift;
		logic [KSTEP_W-1:0] wgt_shift;
		logic               step_valid;
		logic               bias_sel; // 0 bias, 1 psum
	} slide_ctrl_t;

endpackage

/* src/nn_ctrl_top.sv */
// control unit only; image, weight and psum memories and the PE array sit outside
module nn_ctrl_top import nn_ctrl_pkg::*; (
	input  logic             i_clk,
	input  logic             i_rst,
	input  logic             i_cfg_wr_en,
	input  cfg_reg_e         i_cfg_addr,
	input  logic [15:0]      i_cfg_wdata,
	input  logic [DMA_W-1:0] i_dma_data,
	input  logic             i_dma_valid,
	output logic             o_dma_ready,
	output img_wr_t          o_img_wr,
	output wmem_wr_t         o_wmem_wr,
	output slide_ctrl_t      o_slide,
	output pmem_port_t       o_pmem0,
	output pmem_port_t       o_pmem1,
	output logic             o_busy,
	output logic             o_done
);

	cfg_t              cfg;
	logic              start;
	logic [WORD_W-1:0] word_data;
	logic              word_valid;
	logic              word_ready;
	logic              wgt_valid;
	logic              wgt_ready;
	logic [1:0]        bank_full;
	logic              bank_release;
	logic              layer_done;

	nn_cfg_regs u_nn_cfg_regs (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_cfg_wr_en (i_cfg_wr_en),
		.i_cfg_addr  (i_cfg_addr),
		.i_cfg_wdata (i_cfg_wdata),
		.i_busy      (o_busy),
		.o_cfg       (cfg),
		.o_start     (start)
	);

	dma_beat_packer u_dma_beat_packer (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_beat_data  (i_dma_data),
		.i_beat_valid (i_dma_valid),
		.i_word_ready (word_ready),
		.o_beat_ready (o_dma_ready),
		.o_word_data  (word_data),
		.o_word_valid (word_valid)
	);

	layer_phase_ctrl u_layer_phase_ctrl (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_cfg        (cfg),
		.i_start      (start),
		.i_word_data  (word_data),
		.i_word_valid (word_valid),
		.i_wgt_ready  (wgt_ready),
		.i_layer_done (layer_done),
		.o_word_ready (word_ready),
		.o_wgt_valid  (wgt_valid),
		.o_img_wr     (o_img_wr),
		.o_phase      (),
		.o_busy       (o_busy),
		.o_done       (o_done)
	);

	wmem_pingpong_writer u_wmem_pingpong_writer (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_cfg          (cfg),
		.i_start        (start),
		.i_word_data    (word_data),
		.i_word_valid   (wgt_valid),
		.i_bank_release (bank_release),
		.o_word_ready   (wgt_ready),
		.o_wmem_wr      (o_wmem_wr),
		.o_bank_full    (bank_full),
		.o_wr_bank      ()
	);

	conv_sequencer u_conv_sequencer (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_cfg          (cfg),
		.i_start        (start),
		.i_bank_full    (bank_full),
		.o_slide        (o_slide),
		.o_pmem0        (o_pmem0),
		.o_pmem1        (o_pmem1),
		.o_bank_release (bank_release),
		.o_layer_done   (layer_done)
	);

endmodule

/* src/wmem_pingpong_writer.sv */
// one weight row (six column words) per input channel; banks are consumed in fill order
module wmem_pingpong_writer import nn_ctrl_pkg::*; (
	input  logic              i_clk,
	input  logic              i_rst,
	input  cfg_t              i_cfg,
	input  logic              i_start,
	input  logic [WORD_W-1:0] i_word_data,
	input  logic              i_word_valid,
	input  logic              i_bank_release,
	output logic              o_word_ready,
	output wmem_wr_t          o_wmem_wr,
	output logic [1:0]        o_bank_full,
	output logic              o_wr_bank
);

	logic [COL_NUM-1:0] col_oh;
	logic [WMEM_AW-1:0] row_addr;
	logic [CH_W-1:0]    rows_done;
	logic               rd_bank;   // next bank the sequencer frees
	logic               all_written;
	logic               word_fire;
	logic               row_end;
	logic               bank_end;
	logic [1:0]         set_full;
	logic [1:0]         clr_full;
	logic [COL_NUM-1:0] wr_en_q;
	logic [WMEM_AW-1:0] wr_addr_q;
	logic [WORD_W-1:0]  wr_data_q;

	assign all_written  = (rows_done == i_cfg.img_c);
	assign o_word_ready = ~o_bank_full[o_wr_bank] & ~all_written;
	assign word_fire    = i_word_valid & o_word_ready;
	assign row_end      = word_fire & col_oh[COL_NUM-1];
	assign bank_end     = row_end & ((row_addr == '1) || (rows_done + 1'b1 == i_cfg.img_c));

	assign set_full = bank_end ? (2'b01 << o_wr_bank) : 2'b00;
	assign clr_full = i_bank_release ? (2'b01 << rd_bank) : 2'b00;

	assign o_wmem_wr = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			col_oh      <= COL_NUM'(1);
			row_addr    <= '0;
			rows_done   <= '0;
			o_bank_full <= '0;
			o_wr_bank   <= 1'b0;
			rd_bank     <= 1'b0;
			wr_en_q     <= '0;
		end else if (i_start) begin
			col_oh      <= COL_NUM'(1);
			row_addr    <= '0;
			rows_done   <= '0;
			o_bank_full <= '0;
			o_wr_bank   <= 1'b0;
			rd_bank     <= 1'b0;
			wr_en_q     <= '0;
		end else begin
			wr_en_q     <= word_fire ? col_oh : '0;
			o_bank_full <= (o_bank_full | set_full) & ~clr_full;
			if (i_bank_release)
				rd_bank <= ~rd_bank;
			if (word_fire)
				col_oh <= {col_oh[COL_NUM-2:0], col_oh[COL_NUM-1]};
			if (row_end) begin
				rows_done <= rows_done + 1'b1;
				row_addr  <= row_addr + 1'b1;
			end
			if (bank_end) begin
				row_addr  <= '0;
				o_wr_bank <= ~o_wr_bank; // swap to the other bank
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (word_fire) begin
			wr_addr_q <= row_addr;
			wr_data_q <= i_word_data;
		end
	end

endmodule

/* test/tb_nn_ctrl.sv */
// third layer has 260 channels so both weight banks fill and stall the DMA; about 35k cycles
module tb_nn_ctrl import nn_ctrl_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int BEAT_WAIT_MAX = 20000;
	localparam int DONE_WAIT_MAX = 20000;
	localparam int IDLE_WAIT_MAX = 20;

	logic              i_clk = 1'b0;
	logic              i_rst;
	logic              i_cfg_wr_en;
	cfg_reg_e          i_cfg_addr;
	logic [15:0]       i_cfg_wdata;
	logic [DMA_W-1:0]  i_dma_data;
	logic              i_dma_valid;
	logic              o_dma_ready;
	img_wr_t           o_img_wr;
	wmem_wr_t          o_wmem_wr;
	slide_ctrl_t       o_slide;
	pmem_port_t        o_pmem0;
	pmem_port_t        o_pmem1;
	logic              o_busy;
	logic              o_done;

	int mismatch_errs = 0;
	int other_errs = 0;
	int exp_img_c = 0;
	int exp_out_w = 0;
	int exp_k = 0;
	int exp_img_n = 0;
	int exp_steps;
	int exp_shifts;
	int layers_run = 0;

	// reference model state
	int                 beat_total;
	int                 beat_ph;
	logic [WORD_W-1:0]  word_acc;
	logic [WORD_W-1:0]  word_ref [0:255];
	logic [7:0]         word_wr; // wraps with the ring
	logic [7:0]         word_rd;
	logic [WORD_W-1:0]  exp_word;
	int                 words_written;
	int                 full_beats; // beats taken while both banks are full
	int                 img_cnt;
	int                 wgt_cnt;
	int                 wcol;
	logic [WMEM_AW-1:0] waddr;
	int                 step_cnt;
	int                 shift_cnt;
	int                 step_idx;
	int                 ref_ch;
	int                 ref_col;
	int                 ref_row;
	logic [PMEM_AW-1:0] pix_exp;
	logic               prev_step;
	logic [PMEM_AW-1:0] prev_pix;
	logic               prev_wbank;
	logic               prev_done;
	int                 done_cnt;

	nn_ctrl_top u_nn_ctrl_top (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_cfg_wr_en (i_cfg_wr_en),
		.i_cfg_addr  (i_cfg_addr),
		.i_cfg_wdata (i_cfg_wdata),
		.i_dma_data  (i_dma_data),
		.i_dma_valid (i_dma_valid),
		.o_dma_ready (o_dma_ready),
		.o_img_wr    (o_img_wr),
		.o_wmem_wr   (o_wmem_wr),
		.o_slide     (o_slide),
		.o_pmem0     (o_pmem0),
		.o_pmem1     (o_pmem1),
		.o_busy      (o_busy),
		.o_done      (o_done)
	);

	always #4 i_clk = ~i_clk;

	assign exp_word   = word_ref[word_rd];
	assign pix_exp    = PMEM_AW'(ref_col * exp_out_w + ref_row);
	assign exp_steps  = exp_img_c * exp_out_w * exp_out_w * exp_k;
	assign exp_shifts = exp_img_c * exp_out_w * (exp_k + exp_out_w - 1);

	function automatic logic [WORD_W-1:0] place_beat(input logic [WORD_W-1:0] word,
		input int slot, input logic [DMA_W-1:0] beat);
		logic [WORD_W-1:0] res;
		res = word;
		res[slot*DMA_W +: DMA_W] = beat;
		return res;
	endfunction

	task automatic report_mismatch(input string sig, input logic [63:0] got,
		input logic [63:0] exp);
		mismatch_errs++;
		$display("Mismatch %s: got %0h expected %0h at %0t", sig, got, exp, $time);
	endtask

	task automatic report_failure(input string what);
		other_errs++;
		$display("Error: %s at %0t", what, $time);
	endtask

	task automatic finish_run();
		$display("mismatches %0d, other errors %0d", mismatch_errs, other_errs);
		if (mismatch_errs + other_errs == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	task automatic abort_run(input string what);
		report_failure({"timeout waiting for ", what});
		finish_run();
	endtask

	task automatic write_reg(input cfg_reg_e addr, input logic [15:0] data);
		i_cfg_wr_en = 1'b1;
		i_cfg_addr  = addr;
		i_cfg_wdata = data;
		@(posedge i_clk);
		#1;
		i_cfg_wr_en = 1'b0;
	endtask

	task automatic send_beats(input int n);
		int i;
		int gap;
		int wait_cyc;
		logic accepted;
		for (i = 0; i < n; i++) begin
			gap = $urandom_range(0, 2);
			if (gap > 0) begin
				i_dma_valid = 1'b0;
				repeat (gap) begin
					@(posedge i_clk);
					#1;
				end
			end
			i_dma_valid = 1'b1;
			i_dma_data  = DMA_W'($urandom);
			wait_cyc = 0;
			accepted = 1'b0;
			while (!accepted && wait_cyc < BEAT_WAIT_MAX) begin
				accepted = o_dma_ready; // ready as seen by the coming edge
				@(posedge i_clk);
				#1;
				wait_cyc++;
			end
			if (!accepted)
				abort_run("o_dma_ready");
		end
		i_dma_valid = 1'b0;
	endtask

	task automatic run_layer(input kmode_e mode, input int img_n, input int img_c,
		input int out_w, input logic bad_mode);
		int wait_cyc;
		exp_img_c = img_c;
		exp_out_w = out_w;
		exp_img_n = img_n;
		exp_k     = (mode == MODE_K5) ? 5 : 4;
		write_reg(REG_MODE, 16'(mode));
		if (bad_mode)
			write_reg(REG_MODE, 16'd3); // not a kernel mode, must be dropped
		write_reg(REG_IMG_C, 16'(exp_img_c));
		write_reg(REG_OUT_W, 16'(exp_out_w));
		write_reg(REG_IMG_WORDS, 16'(img_n - 1));
		write_reg(REG_START, 16'd0);
		send_beats(BEATS_PER_WORD * (img_n + exp_img_c * COL_NUM));
		wait_cyc = 0;
		while (!o_done && wait_cyc < DONE_WAIT_MAX) begin
			@(posedge i_clk);
			#1;
			wait_cyc++;
		end
		if (!o_done)
			abort_run("o_done");
		layers_run++;
		wait_cyc = 0;
		while (o_busy && wait_cyc < IDLE_WAIT_MAX) begin
			@(posedge i_clk);
			#1;
			wait_cyc++;
		end
		if (o_busy)
			abort_run("o_busy to fall");
		a_done_once: assert (done_cnt == layers_run)
			else report_mismatch("o_done count", done_cnt, layers_run);
	endtask

	always @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			beat_total    <= 0;
			beat_ph       <= 0;
			word_acc      <= '0;
			word_wr       <= '0;
			word_rd       <= '0;
			words_written <= 0;
			full_beats    <= 0;
			img_cnt       <= 0;
			wgt_cnt       <= 0;
			wcol          <= 0;
			waddr         <= '0;
			step_cnt      <= 0;
			shift_cnt     <= 0;
			step_idx      <= 0;
			ref_ch        <= 0;
			ref_col       <= 0;
			ref_row       <= 0;
			prev_step     <= 1'b0;
			prev_pix      <= '0;
			prev_wbank    <= 1'b0;
			prev_done     <= 1'b0;
			done_cnt      <= 0;
		end else begin
			if (i_dma_valid && o_dma_ready) begin
				beat_total <= beat_total + 1;
				if (beat_ph == BEATS_PER_WORD - 1) begin
					word_ref[word_wr] <= place_beat(word_acc, beat_ph, i_dma_data);
					word_wr <= word_wr + 1'b1;
					beat_ph <= 0;
				end else begin
					word_acc <= place_beat(word_acc, beat_ph, i_dma_data);
					beat_ph  <= beat_ph + 1;
				end
			end
			if (u_nn_ctrl_top.bank_full == 2'b11) begin
				if (i_dma_valid && o_dma_ready)
					full_beats <= full_beats + 1;
			end else begin
				full_beats <= 0;
			end
			if (o_img_wr.en || o_wmem_wr.en != '0)
				words_written <= words_written + 1;
			if (o_img_wr.en) begin
				word_rd <= word_rd + 1'b1;
				img_cnt <= img_cnt + 1;
			end
			if (o_wmem_wr.en != '0) begin
				word_rd <= word_rd + 1'b1;
				wgt_cnt <= wgt_cnt + 1;
				wcol    <= (wcol == COL_NUM - 1) ? 0 : wcol + 1;
				if (wcol == COL_NUM - 1)
					waddr <= waddr + 1'b1;
			end
			if (o_slide.shift)
				shift_cnt <= shift_cnt + 1;
			if (o_slide.step_valid) begin
				step_cnt <= step_cnt + 1;
				step_idx <= step_idx + 1;
				if (step_idx == exp_k - 1) begin
					step_idx <= 0;
					ref_row  <= ref_row + 1;
					if (ref_row == exp_out_w - 1) begin
						ref_row <= 0;
						ref_col <= ref_col + 1;
						if (ref_col == exp_out_w - 1) begin
							ref_col <= 0;
							ref_ch  <= ref_ch + 1;
						end
					end
				end
			end
			prev_step  <= o_slide.step_valid;
			prev_pix   <= pix_exp;
			prev_wbank <= ~ref_ch[0]; // write goes to the other psum bank
			prev_done  <= o_done;
			if (o_done) begin
				done_cnt  <= done_cnt + 1;
				img_cnt   <= 0;
				wgt_cnt   <= 0;
				wcol      <= 0;
				waddr     <= '0;
				step_cnt  <= 0;
				shift_cnt <= 0;
				step_idx  <= 0;
				ref_ch    <= 0;
				ref_col   <= 0;
				ref_row   <= 0;
			end
		end
	end

	// image buffer writes
	a_img_addr: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_img_wr.en |-> o_img_wr.addr == img_cnt)
		else report_mismatch("o_img_wr.addr", $sampled(o_img_wr.addr), $sampled(img_cnt));
	a_img_data: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_img_wr.en |-> o_img_wr.data == exp_word)
		else report_mismatch("o_img_wr.data", $sampled(o_img_wr.data), $sampled(exp_word));

	// weight buffer writes
	a_wgt_order: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_wmem_wr.en != '0 |-> img_cnt == exp_img_n && !o_img_wr.en)
		else report_failure("weight write before the image load finished");
	a_wgt_col: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_wmem_wr.en != '0 |-> o_wmem_wr.en == COL_NUM'(1) << wcol)
		else report_mismatch("o_wmem_wr.en", $sampled(o_wmem_wr.en),
			COL_NUM'(1) << $sampled(wcol));
	a_wgt_addr: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_wmem_wr.en != '0 |-> o_wmem_wr.addr == waddr)
		else report_mismatch("o_wmem_wr.addr", $sampled(o_wmem_wr.addr), $sampled(waddr));
	a_wgt_data: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_wmem_wr.en != '0 |-> o_wmem_wr.data == exp_word)
		else report_mismatch("o_wmem_wr.data", $sampled(o_wmem_wr.data), $sampled(exp_word));
	// at most the word already being packed gets through
	a_full_stall: assert property (@(posedge i_clk) disable iff (!i_rst)
		u_nn_ctrl_top.bank_full == 2'b11 |-> full_beats <= BEATS_PER_WORD)
		else report_failure("DMA beats still taken with both weight banks full");

	// step runs and shifts
	a_wgt_shift: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_slide.step_valid |-> o_slide.wgt_shift == step_idx)
		else report_mismatch("o_slide.wgt_shift", $sampled(o_slide.wgt_shift),
			$sampled(step_idx));
	a_no_gap: assert property (@(posedge i_clk) disable iff (!i_rst)
		step_idx != 0 |-> o_slide.step_valid && !o_slide.shift)
		else report_failure("step run broken before wgt_shift reached K-1");

	// psum bank and address rules
	a_bias_ch0: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_slide.step_valid && ref_ch == 0 |-> !o_slide.bias_sel
			&& !o_pmem0.rd_en && !o_pmem1.rd_en)
		else report_failure("channel 0 step reads psum or selects psum");
	a_acc_sel: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_slide.step_valid && ref_ch != 0 |-> o_slide.bias_sel)
		else report_mismatch("o_slide.bias_sel", $sampled(o_slide.bias_sel), 1);
	a_rd_bank: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_slide.step_valid && ref_ch != 0 |->
			{o_pmem1.rd_en, o_pmem0.rd_en} == (ref_ch[0] ? 2'b10 : 2'b01))
		else report_mismatch("pmem rd_en {1,0}", {$sampled(o_pmem1.rd_en),
			$sampled(o_pmem0.rd_en)}, $sampled(ref_ch[0]) ? 2'b10 : 2'b01);
	a_rd_addr: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_slide.step_valid && ref_ch != 0 |->
			(ref_ch[0] ? o_pmem1.rd_addr : o_pmem0.rd_addr) == pix_exp)
		else report_mismatch("pmem rd_addr", $sampled(ref_ch[0]) ?
			$sampled(o_pmem1.rd_addr) : $sampled(o_pmem0.rd_addr), $sampled(pix_exp));
	a_rd_idle: assert property (@(posedge i_clk) disable iff (!i_rst)
		!o_slide.step_valid |-> !o_pmem0.rd_en && !o_pmem1.rd_en)
		else report_failure("psum read outside a step");
	a_wr_bank: assert property (@(posedge i_clk) disable iff (!i_rst)
		{o_pmem1.wr_en, o_pmem0.wr_en} == (!prev_step ? 2'b00 : prev_wbank ? 2'b10 : 2'b01))
		else report_mismatch("pmem wr_en {1,0}", {$sampled(o_pmem1.wr_en),
			$sampled(o_pmem0.wr_en)}, !$sampled(prev_step) ? 2'b00 :
			$sampled(prev_wbank) ? 2'b10 : 2'b01);
	a_wr_addr: assert property (@(posedge i_clk) disable iff (!i_rst)
		prev_step |-> (prev_wbank ? o_pmem1.wr_addr : o_pmem0.wr_addr) == prev_pix)
		else report_mismatch("pmem wr_addr", $sampled(prev_wbank) ?
			$sampled(o_pmem1.wr_addr) : $sampled(o_pmem0.wr_addr), $sampled(prev_pix));

	// per layer totals, sampled on the done pulse
	a_img_total: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_done |-> img_cnt == exp_img_n)
		else report_mismatch("image write count", $sampled(img_cnt), $sampled(exp_img_n));
	a_wgt_total: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_done |-> wgt_cnt == exp_img_c * COL_NUM)
		else report_mismatch("weight write count", $sampled(wgt_cnt),
			$sampled(exp_img_c) * COL_NUM);
	a_step_total: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_done |-> step_cnt == exp_steps)
		else report_mismatch("step_valid count", $sampled(step_cnt), $sampled(exp_steps));
	a_shift_total: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_done |-> shift_cnt == exp_shifts)
		else report_mismatch("shift count", $sampled(shift_cnt), $sampled(exp_shifts));
	a_done_pulse: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_done |-> !prev_done)
		else report_failure("o_done held longer than one cycle");

	// quiet outputs in reset and while idle
	a_reset_quiet: assert property (@(posedge i_clk)
		!i_rst |-> !o_busy && !o_done && !o_img_wr.en && o_wmem_wr.en == '0
			&& !o_slide.step_valid && !o_slide.shift && !o_dma_ready
			&& !o_pmem0.wr_en && !o_pmem1.wr_en && !o_pmem0.rd_en && !o_pmem1.rd_en)
		else report_failure("outputs active during reset");
	a_idle_quiet: assert property (@(posedge i_clk) disable iff (!i_rst)
		!o_busy |-> !o_img_wr.en && o_wmem_wr.en == '0 && !o_slide.step_valid
			&& !o_slide.shift && !o_done)
		else report_failure("activity while the layer is idle");

	initial begin
		void'($urandom(73786));
		i_rst       = 1'b1;
		i_cfg_wr_en = 1'b0;
		i_cfg_addr  = REG_MODE;
		i_cfg_wdata = '0;
		i_dma_data  = '0;
		i_dma_valid = 1'b0;
		#1;
		i_rst = 1'b0;
		repeat (5) @(posedge i_clk);
		#1;
		i_rst = 1'b1;
		repeat (2) begin
			@(posedge i_clk);
			#1;
		end
		run_layer(MODE_K4, 5, 3, 4, 1'b0);
		run_layer(MODE_K5, 7, 3, 4, 1'b1);
		run_layer(MODE_K4, 4, 260, 4, 1'b0); // more rows than two banks hold
		repeat (4) begin
			@(posedge i_clk);
			#1;
		end
		a_beat_total: assert (beat_total == BEATS_PER_WORD * words_written)
			else report_mismatch("accepted beat count", beat_total,
				BEATS_PER_WORD * words_written);
		finish_run();
	end

endmodule

/* verilog.f */
src/nn_ctrl_pkg.sv
src/nn_cfg_regs.sv
src/dma_beat_packer.sv
src/layer_phase_ctrl.sv
src/wmem_pingpong_writer.sv
src/conv_sequencer.sv
src/nn_ctrl_top.sv
test/tb_nn_ctrl.sv
